/* src/smd_pkg.sv */
package smd_pkg;

    localparam int DATA_W = 64;
    localparam int ADDR_W = 48;
    localparam int IDX_W = 32;
    localparam int NUM_REGS = 5;
    localparam int CW_W = 4;
    // table index field, codes up to 8 bits
    localparam int TBL_ADDR_W = 8;
    // bit buffer capacity and its count width
    localparam int BUF_W = 128;
    localparam int CNT_W = 8;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_RST = 4'd1,
        OP_LD = 4'd2,
        OP_LD_CODES = 4'd3,
        OP_STEADY = 4'd4
    } opcode_e;

    // command word, opcode in the low bits
    typedef struct packed {
        logic [ADDR_W-1:0] value;
        logic [3:0] reg_idx;
        logic broadcast;
        logic [6:0] pe;
        opcode_e opcode;
    } op_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_CODES,
        STEADY_CODE,
        STEADY_ARG
    } state_e;

    typedef enum logic [1:0] {
        SYM_NEWLINE = 2'd0,
        SYM_CONSTANT = 2'd1,
        SYM_RANGE = 2'd2
    } sym_kind_e;

    typedef struct packed {
        logic [4:0] delta;
        sym_kind_e kind;
    } symbol_t;

    typedef struct packed {
        symbol_t symbol;
        logic [CW_W-1:0] code_width;
    } table_entry_t;

    typedef struct packed {
        logic [DATA_W-$bits(table_entry_t)-1:0] pad;
        table_entry_t entry;
    } entry_word_t;

    // raw stream bits, or a code table entry while loading codes
    typedef union packed {
        logic [DATA_W-1:0] raw;
        entry_word_t ent;
    } mem_word_u;

    typedef struct packed {
        logic [TBL_ADDR_W-1:0] addr;
        table_entry_t entry;
    } table_wr_t;

    // tag 0 is the code stream, tag 1 the argument stream
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic tag;
    } mem_req_t;

    typedef struct packed {
        logic tag;
        mem_word_u data;
    } mem_rsp_t;

    typedef struct packed {
        logic [IDX_W-1:0] row;
        logic [IDX_W-1:0] col;
    } index_t;

endpackage

/* src/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo
    import smd_pkg::*;
#(
    parameter int DEPTH = 32,
    parameter int AFULL_SLACK = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic [DATA_W-1:0] din,
    input  logic pop,
    output logic [DATA_W-1:0] dout,
    output logic empty,
    output logic almost_full
);

    localparam int AW = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;

    // head word is visible without a pop
    assign dout = mem[rd_ptr];
    assign empty = count == '0;
    assign almost_full = count >= (AW+1)'(DEPTH - AFULL_SLACK);

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= din;
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

endmodule

/* src/bit_buffer.sv */
`timescale 1ns/10ps

module bit_buffer
    import smd_pkg::*;
#(
    parameter int WINDOW_W = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic [DATA_W-1:0] word,
    input  logic word_valid,
    input  logic [CNT_W-1:0] consume_n,
    input  logic consume,
    output logic word_ready,
    output logic [WINDOW_W-1:0] window,
    output logic [CNT_W-1:0] bit_count
);

    logic [BUF_W-1:0] bits_q;
    logic [BUF_W-1:0] next_bits;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] kept;
    logic load;

    // room for a whole word on top of what is held
    assign word_ready = count <= CNT_W'(BUF_W - DATA_W);
    assign load = word_valid && word_ready;
    assign window = bits_q[WINDOW_W-1:0];
    assign bit_count = count;

    always_comb begin
        next_bits = bits_q;
        kept = count;
        if (consume) begin
            next_bits = bits_q >> consume_n;
            kept = count - consume_n;
        end
        // new word goes just above the remaining bits, upper bits stay zero
        if (load)
            next_bits = next_bits | ({{(BUF_W-DATA_W){1'b0}}, word} << kept);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_q <= '0;
            count <= '0;
        end else begin
            bits_q <= next_bits;
            count <= load ? kept + CNT_W'(DATA_W) : kept;
        end
    end

endmodule

/* src/response_router.sv */
`timescale 1ns/10ps

module response_router
    import smd_pkg::*;
#(
    parameter int FIFO_DEPTH = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic steady,
    input  logic rsp_mem_push,
    input  mem_rsp_t rsp_mem,
    input  logic code_ready,
    input  logic arg_ready,
    output logic [DATA_W-1:0] code_word,
    output logic code_valid,
    output logic [DATA_W-1:0] arg_word,
    output logic arg_valid,
    output logic [1:0] fifo_afull,
    output logic rsp_mem_stall
);

    // room kept above the threshold for responses still in flight
    localparam int RSP_SLACK = 8;

    logic [1:0] push;
    logic [1:0] pop;
    logic [1:0] empty;

    assign code_valid = !empty[0];
    assign arg_valid = !empty[1];
    assign pop = {arg_valid && arg_ready, code_valid && code_ready};

    for (genvar t = 0; t < 2; t++) begin : g_tag
        assign push[t] = rsp_mem_push && steady && rsp_mem.tag == 1'(t);
    end

    word_fifo #(.DEPTH(FIFO_DEPTH), .AFULL_SLACK(RSP_SLACK)) u_code_fifo (
        .clk(clk), .rst(rst), .push(push[0]), .din(rsp_mem.data.raw), .pop(pop[0]),
        .dout(code_word), .empty(empty[0]), .almost_full(fifo_afull[0])
    );

    word_fifo #(.DEPTH(FIFO_DEPTH), .AFULL_SLACK(RSP_SLACK)) u_arg_fifo (
        .clk(clk), .rst(rst), .push(push[1]), .din(rsp_mem.data.raw), .pop(pop[1]),
        .dout(arg_word), .empty(empty[1]), .almost_full(fifo_afull[1])
    );

    always_ff @(posedge clk) begin
        if (rst)
            rsp_mem_stall <= 1'b0;
        else
            rsp_mem_stall <= |fifo_afull;
    end

endmodule

/* src/code_table_decoder.sv */
`timescale 1ns/10ps

module code_table_decoder
    import smd_pkg::*;
#(
    parameter int MAX_CODE_LEN = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic [DATA_W-1:0] code_word,
    input  logic code_valid,
    input  table_wr_t table_wr,
    input  logic table_wr_en,
    input  logic sym_pop,
    output logic code_ready,
    output logic sym_valid,
    output symbol_t symbol
);

    table_entry_t code_table [2**MAX_CODE_LEN];
    table_entry_t entry;
    logic [MAX_CODE_LEN-1:0] window;
    logic [CNT_W-1:0] bit_count;

    // a short code fills every slot that shares its prefix
    always_ff @(posedge clk) begin
        if (table_wr_en)
            code_table[table_wr.addr[MAX_CODE_LEN-1:0]] <= table_wr.entry;
    end

    assign entry = code_table[window];
    assign symbol = entry.symbol;
    // zero width marks an unused slot
    assign sym_valid = entry.code_width != '0 && bit_count >= CNT_W'(entry.code_width);

    bit_buffer #(.WINDOW_W(MAX_CODE_LEN)) u_code_bits (
        .clk(clk),
        .rst(rst),
        .word(code_word),
        .word_valid(code_valid),
        .consume_n(CNT_W'(entry.code_width)),
        .consume(sym_pop),
        .word_ready(code_ready),
        .window(window),
        .bit_count(bit_count)
    );

endmodule

/* src/index_accumulator.sv */
`timescale 1ns/10ps

module index_accumulator
    import smd_pkg::*;
#(
    parameter int SUB_WIDTH_LOG2 = 4,
    parameter int SUB_HEIGHT_LOG2 = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic sym_valid,
    input  symbol_t symbol,
    input  logic [IDX_W-1:0] arg_window,
    input  logic [CNT_W-1:0] arg_count,
    input  logic stall_index,
    input  logic enable,
    output logic sym_pop,
    output logic arg_consume,
    output logic [CNT_W-1:0] arg_n,
    output logic push_index,
    output index_t row_col
);

    localparam int WL = SUB_WIDTH_LOG2;
    localparam int HL = SUB_HEIGHT_LOG2;

    logic is_range;
    logic s1_valid;
    sym_kind_e s1_kind;
    logic [4:0] s1_delta;
    logic [IDX_W-1:0] s1_arg;
    logic s2_valid;
    logic s2_newline;
    logic [IDX_W-1:0] s2_delta;
    logic push_q;
    index_t acc;
    logic [WL:0] lo_col;
    logic [HL:0] lo_row;
    logic [IDX_W-WL-1:0] hi_col;
    logic [IDX_W-HL-1:0] hi_row;

    // pop stage, range symbols need their argument bits on hand
    assign is_range = symbol.kind == SYM_RANGE;
    assign arg_n = CNT_W'(symbol.delta);
    assign sym_pop = enable && sym_valid && !stall_index && (!is_range || arg_count >= arg_n);
    assign arg_consume = sym_pop && is_range;

    assign push_index = push_q && enable;
    assign row_col = acc;

    // carries run col low -> row low -> col high
    always_comb begin
        lo_col = {1'b0, acc.col[WL-1:0]} + {1'b0, s2_delta[WL-1:0]};
        lo_row = {1'b0, acc.row[HL-1:0]} + {1'b0, s2_delta[WL +: HL]} + (HL+1)'(lo_col[WL]);
        hi_col = acc.col[IDX_W-1:WL] + (IDX_W-WL)'(s2_delta[IDX_W-1:WL+HL])
            + (IDX_W-WL)'(lo_row[HL]);
        hi_row = acc.row[IDX_W-1:HL];
        if (s2_newline) begin
            lo_col = '1;
            lo_row = '1;
            hi_col = '1;
            hi_row = acc.row[IDX_W-1:HL] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        s1_kind <= symbol.kind;
        s1_delta <= symbol.delta;
        s1_arg <= arg_window & ~({IDX_W{1'b1}} << symbol.delta);
        s2_newline <= s1_kind == SYM_NEWLINE;
        case (s1_kind)
            SYM_RANGE: s2_delta <= (s1_arg | (IDX_W'(1) << s1_delta)) + 1'b1;
            SYM_CONSTANT: s2_delta <= IDX_W'(s1_delta) + 1'b1;
            default: s2_delta <= '0;
        endcase
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            push_q <= 1'b0;
            acc.row <= IDX_W'((1 << HL) - 1);
            acc.col <= '1;
        end else begin
            s1_valid <= sym_pop;
            s2_valid <= s1_valid;
            push_q <= s2_valid && !s2_newline;
            if (s2_valid) begin
                acc.row <= {hi_row, lo_row[HL-1:0]};
                acc.col <= {hi_col, lo_col[WL-1:0]};
            end
        end
    end

endmodule

/* src/decoder_control.sv */
`timescale 1ns/10ps

module decoder_control
    import smd_pkg::*;
#(
    parameter int ID = 0
) (
    input  logic clk,
    input  logic rst,
    input  op_t op,
    input  logic req_mem_stall,
    input  logic rsp_mem_push,
    input  mem_rsp_t rsp_mem,
    input  logic [1:0] fifo_afull,
    input  logic push_index,
    output logic busy,
    output logic req_mem_ld,
    output mem_req_t req_mem,
    output table_wr_t table_wr,
    output logic table_wr_en,
    output logic steady,
    output logic decode_rst
);

    op_t op_r;
    logic op_active;
    state_e state;
    state_e next_state;
    logic [ADDR_W-1:0] regs [NUM_REGS];
    logic [ADDR_W-1:0] next_regs [NUM_REGS];
    logic req_stall_r;
    logic next_req_ld;
    mem_req_t next_req;
    logic code_done;
    logic arg_done;
    logic in_steady;

    assign op_active = op_r.opcode != OP_NOP && (op_r.broadcast || op_r.pe == 7'(ID));
    assign code_done = regs[0] == regs[2];
    assign arg_done = regs[1] == regs[3];
    assign in_steady = state == STEADY_CODE || state == STEADY_ARG;
    // decoding stops as soon as the element count runs out
    assign steady = in_steady && regs[4] != '0;

    // table writes come straight off the response bus
    assign table_wr_en = state == LOAD_CODES && rsp_mem_push;
    assign table_wr.addr = TBL_ADDR_W'(regs[1] >> 3);
    assign table_wr.entry = rsp_mem.data.ent.entry;

    always_comb begin
        next_state = state;
        next_regs = regs;
        next_req_ld = 1'b0;
        next_req.addr = regs[0];
        next_req.tag = 1'b0;
        case (state)
            LOAD_CODES: begin
                if (!code_done && !req_stall_r) begin
                    next_req_ld = 1'b1;
                    next_regs[0] = regs[0] + ADDR_W'(8);
                end
                if (rsp_mem_push)
                    next_regs[1] = regs[1] + ADDR_W'(8);
                if (arg_done)
                    next_state = IDLE;
            end
            STEADY_CODE: begin
                if (!code_done && !req_stall_r && !fifo_afull[0]) begin
                    next_req_ld = 1'b1;
                    next_regs[0] = regs[0] + ADDR_W'(8);
                end
                if (next_req_ld || code_done || fifo_afull[0])
                    next_state = STEADY_ARG;
            end
            STEADY_ARG: begin
                next_req.addr = regs[1];
                next_req.tag = 1'b1;
                if (!arg_done && !req_stall_r && !fifo_afull[1]) begin
                    next_req_ld = 1'b1;
                    next_regs[1] = regs[1] + ADDR_W'(8);
                end
                if (next_req_ld || arg_done || fifo_afull[1])
                    next_state = STEADY_CODE;
            end
            default: ;
        endcase

        // element count
        if (steady && push_index)
            next_regs[4] = regs[4] - ADDR_W'(1);
        if (in_steady && regs[4] == '0)
            next_state = IDLE;

        if (op_active) begin
            case (op_r.opcode)
                OP_RST: next_state = IDLE;
                OP_LD_CODES: next_state = LOAD_CODES;
                OP_STEADY: next_state = STEADY_CODE;
                OP_LD: begin
                    for (int i = 0; i < NUM_REGS; i++)
                        if (op_r.reg_idx == 4'(i))
                            next_regs[i] = op_r.value;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        req_stall_r <= req_mem_stall;
        req_mem <= next_req;
        regs <= next_regs;
        if (rst) begin
            op_r <= '0;
            state <= IDLE;
            busy <= 1'b0;
            req_mem_ld <= 1'b0;
            decode_rst <= 1'b0;
        end else begin
            op_r <= op;
            state <= next_state;
            // busy trails the state by a cycle
            busy <= state != IDLE;
            req_mem_ld <= next_req_ld;
            decode_rst <= op_active && op_r.opcode == OP_RST;
        end
    end

endmodule

/* src/sparse_index_decoder.sv */
`timescale 1ns/10ps

module sparse_index_decoder
    import smd_pkg::*;
#(
    parameter int ID = 0,
    parameter int MAX_CODE_LEN = 6,
    parameter int SUB_WIDTH_LOG2 = 4,
    parameter int SUB_HEIGHT_LOG2 = 4,
    parameter int FIFO_DEPTH = 32
) (
    input  logic clk,
    input  logic rst,
    input  op_t op,
    output logic busy,
    output logic req_mem_ld,
    output mem_req_t req_mem,
    input  logic req_mem_stall,
    input  logic rsp_mem_push,
    input  mem_rsp_t rsp_mem,
    output logic rsp_mem_stall,
    output logic push_index,
    output index_t row_col,
    input  logic stall_index
);

    table_wr_t table_wr;
    logic table_wr_en;
    logic steady;
    logic decode_rst;
    logic dp_rst;
    logic [1:0] fifo_afull;
    logic [DATA_W-1:0] code_word;
    logic [DATA_W-1:0] arg_word;
    logic code_valid;
    logic code_ready;
    logic arg_valid;
    logic arg_ready;
    logic sym_valid;
    logic sym_pop;
    symbol_t symbol;
    logic [IDX_W-1:0] arg_window;
    logic [CNT_W-1:0] arg_count;
    logic [CNT_W-1:0] arg_n;
    logic arg_consume;

    // datapath also clears on the reset command
    assign dp_rst = rst || decode_rst;

    decoder_control #(.ID(ID)) u_control (
        .clk(clk), .rst(rst), .op(op), .req_mem_stall(req_mem_stall),
        .rsp_mem_push(rsp_mem_push), .rsp_mem(rsp_mem), .fifo_afull(fifo_afull),
        .push_index(push_index), .busy(busy), .req_mem_ld(req_mem_ld), .req_mem(req_mem),
        .table_wr(table_wr), .table_wr_en(table_wr_en), .steady(steady),
        .decode_rst(decode_rst)
    );

    response_router #(.FIFO_DEPTH(FIFO_DEPTH)) u_router (
        .clk(clk), .rst(dp_rst), .steady(steady), .rsp_mem_push(rsp_mem_push),
        .rsp_mem(rsp_mem), .code_ready(code_ready), .arg_ready(arg_ready),
        .code_word(code_word), .code_valid(code_valid), .arg_word(arg_word),
        .arg_valid(arg_valid), .fifo_afull(fifo_afull), .rsp_mem_stall(rsp_mem_stall)
    );

    code_table_decoder #(.MAX_CODE_LEN(MAX_CODE_LEN)) u_codes (
        .clk(clk), .rst(dp_rst), .code_word(code_word), .code_valid(code_valid),
        .table_wr(table_wr), .table_wr_en(table_wr_en), .sym_pop(sym_pop),
        .code_ready(code_ready), .sym_valid(sym_valid), .symbol(symbol)
    );

    // argument stream, raw bits
    bit_buffer #(.WINDOW_W(IDX_W)) u_arg_bits (
        .clk(clk), .rst(dp_rst), .word(arg_word), .word_valid(arg_valid),
        .consume_n(arg_n), .consume(arg_consume), .word_ready(arg_ready),
        .window(arg_window), .bit_count(arg_count)
    );

    index_accumulator #(
        .SUB_WIDTH_LOG2(SUB_WIDTH_LOG2),
        .SUB_HEIGHT_LOG2(SUB_HEIGHT_LOG2)
    ) u_accum (
        .clk(clk), .rst(dp_rst), .sym_valid(sym_valid), .symbol(symbol),
        .arg_window(arg_window), .arg_count(arg_count), .stall_index(stall_index),
        .enable(steady), .sym_pop(sym_pop), .arg_consume(arg_consume), .arg_n(arg_n),
        .push_index(push_index), .row_col(row_col)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verif/sparse_index_decoder_tb.sv */
`timescale 1ns/10ps

module sparse_index_decoder_tb
    import smd_pkg::*;
;

    localparam int PE_ID = 5;
    localparam int MAX_CODE_LEN = 6;
    localparam int SUB_W = 4;
    localparam int SUB_H = 4;
    localparam int FIFO_DEPTH = 32;
    localparam int N_INDEX = 300;
    localparam int MEM_WORDS = 4096;
    localparam int CODE_BASE = 'h1000;
    localparam int ARG_BASE = 'h4000;

    // prefix code, first stream bit is bit 0 of the code value
    localparam sym_kind_e SYM_KIND [8] = '{SYM_CONSTANT, SYM_CONSTANT, SYM_RANGE, SYM_RANGE,
                                          SYM_NEWLINE, SYM_CONSTANT, SYM_RANGE, SYM_RANGE};
    localparam int SYM_DELTA [8] = '{0, 3, 4, 9, 0, 20, 1, 0};
    localparam int CODE_VAL [8] = '{2'b00, 3'b010, 3'b110, 4'b0001, 4'b0101, 4'b1001,
                                    5'b00011, 5'b00111};
    localparam int CODE_LEN [8] = '{2, 3, 3, 4, 4, 4, 5, 5};

    logic clk;
    logic rst;
    op_t op = '0;
    logic req_mem_stall = 1'b0;
    logic rsp_mem_push = 1'b0;
    mem_rsp_t rsp_mem = '0;
    logic stall_index = 1'b0;
    logic busy;
    logic req_mem_ld;
    mem_req_t req_mem;
    logic rsp_mem_stall;
    logic push_index;
    index_t row_col;

    logic [31:0] lfsr_state = 32'd67827;
    logic [DATA_W-1:0] mem_words [MEM_WORDS];
    logic [ADDR_W-1:0] pend_addr [$];
    logic pend_tag [$];
    int pend_due [$];
    logic [ADDR_W-1:0] log_addr [$];
    logic log_tag [$];
    index_t ref_seq [$];
    index_t exp_q [$];
    int n_code_words;
    int n_arg_words;
    int cycles = 0;
    int timeout_limit = 2000;
    int rsp_count = 0;
    int push_count = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic stall_en = 1'b0;

    tb_clock_gen #(.HALF_PERIOD(5), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

    sparse_index_decoder #(
        .ID(PE_ID),
        .MAX_CODE_LEN(MAX_CODE_LEN),
        .SUB_WIDTH_LOG2(SUB_W),
        .SUB_HEIGHT_LOG2(SUB_H),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk(clk), .rst(rst), .op(op), .busy(busy), .req_mem_ld(req_mem_ld),
        .req_mem(req_mem), .req_mem_stall(req_mem_stall), .rsp_mem_push(rsp_mem_push),
        .rsp_mem(rsp_mem), .rsp_mem_stall(rsp_mem_stall), .push_index(push_index),
        .row_col(row_col), .stall_index(stall_index)
    );

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v[i] = fb;
        end
        return v;
    endfunction

    // argument bits sit below bit d, so setting bit d is an add
    function automatic logic [IDX_W-1:0] form_delta(input sym_kind_e kind, input int dfield,
                                                    input logic [IDX_W-1:0] argv);
        if (kind == SYM_RANGE)
            return IDX_W'(longint'(argv) + (longint'(1) << dfield) + 1);
        return IDX_W'(dfield + 1);
    endfunction

    // expected position after one symbol, sub-block tiling
    function automatic index_t step_index(input index_t cur, input sym_kind_e kind,
                                          input logic [IDX_W-1:0] delta);
        longint m_w;
        longint m_h;
        longint d;
        longint row_hi;
        longint row_lo;
        longint col_hi;
        longint col_lo;
        longint sum;
        index_t nxt;
        m_w = longint'(1) << SUB_W;
        m_h = longint'(1) << SUB_H;
        d = longint'(delta);
        row_hi = longint'(cur.row) / m_h;
        row_lo = longint'(cur.row) % m_h;
        col_hi = longint'(cur.col) / m_w;
        col_lo = longint'(cur.col) % m_w;
        if (kind == SYM_NEWLINE) begin
            nxt.row = IDX_W'((row_hi + 1) * m_h + (m_h - 1));
            nxt.col = '1;
        end else begin
            sum = col_lo + d % m_w;
            col_lo = sum % m_w;
            sum = row_lo + (d / m_w) % m_h + sum / m_w;
            row_lo = sum % m_h;
            col_hi = col_hi + d / (m_w * m_h) + sum / m_h;
            nxt.row = IDX_W'(row_hi * m_h + row_lo);
            nxt.col = IDX_W'(col_hi * m_w + col_lo);
        end
        return nxt;
    endfunction

    function automatic op_t make_op(input opcode_e opc, input int pe, input logic bc,
                                    input int idx, input logic [ADDR_W-1:0] val);
        op_t o;
        o.opcode = opc;
        o.pe = 7'(pe);
        o.broadcast = bc;
        o.reg_idx = 4'(idx);
        o.value = val;
        return o;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error at time %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != test_errors)
            tests_failed++;
        $display("%s: %s (%0d errors)", name, errors == test_errors ? "ok" : "FAILED",
                 errors - test_errors);
        test_errors = errors;
    endtask

    task automatic build_memory();
        mem_word_u w;
        index_t cur;
        logic [IDX_W-1:0] argv;
        logic [31:0] b1;
        int k;
        int n_idx;
        logic code_bits [$];
        logic arg_bits [$];
        for (int i = 0; i < MEM_WORDS; i++)
            mem_words[i] = {32'(i) ^ 32'h5a5a_0f0f, ~32'(i * 7)};
        // every table slot whose low bits match a code gets that entry
        for (int i = 0; i < 2**MAX_CODE_LEN; i++) begin
            w.raw = '0;
            for (int s = 0; s < 8; s++) begin
                if ((i % (1 << CODE_LEN[s])) == CODE_VAL[s]) begin
                    w.ent.entry.symbol.kind = SYM_KIND[s];
                    w.ent.entry.symbol.delta = 5'(SYM_DELTA[s]);
                    w.ent.entry.code_width = CW_W'(CODE_LEN[s]);
                end
            end
            mem_words[i] = w.raw;
        end
        cur.row = IDX_W'((1 << SUB_H) - 1);
        cur.col = '1;
        n_idx = 0;
        while (n_idx < N_INDEX) begin
            k = int'(take_bits(3));
            for (int b = 0; b < CODE_LEN[k]; b++)
                code_bits.push_back(((CODE_VAL[k] >> b) & 1) != 0);
            argv = '0;
            if (SYM_KIND[k] == SYM_RANGE) begin
                for (int b = 0; b < SYM_DELTA[k]; b++) begin
                    b1 = take_bits(1);
                    argv[b] = b1[0];
                    arg_bits.push_back(b1[0]);
                end
            end
            cur = step_index(cur, SYM_KIND[k], form_delta(SYM_KIND[k], SYM_DELTA[k], argv));
            if (SYM_KIND[k] != SYM_NEWLINE) begin
                ref_seq.push_back(cur);
                n_idx++;
            end
        end
        n_code_words = (code_bits.size() + 63) / 64;
        n_arg_words = (arg_bits.size() + 63) / 64;
        if (n_arg_words == 0)
            n_arg_words = 1;
        for (int i = 0; i < n_code_words; i++)
            mem_words[CODE_BASE / 8 + i] = '0;
        for (int i = 0; i < n_arg_words; i++)
            mem_words[ARG_BASE / 8 + i] = '0;
        for (int j = 0; j < code_bits.size(); j++)
            mem_words[CODE_BASE / 8 + j / 64][j % 64] = code_bits[j];
        for (int j = 0; j < arg_bits.size(); j++)
            mem_words[ARG_BASE / 8 + j / 64][j % 64] = arg_bits[j];
        timeout_limit = 40 * (64 + 2 * (n_code_words + n_arg_words)) + 2000;
    endtask

    task automatic drive_op(input op_t w);
        @(negedge clk);
        op = w;
        @(negedge clk);
        op = '0;
    endtask

    task automatic load_reg(input int idx, input logic [ADDR_W-1:0] val);
        drive_op(make_op(OP_LD, PE_ID, 1'b0, idx, val));
    endtask

    task automatic load_stream_regs();
        load_reg(0, ADDR_W'(CODE_BASE));
        load_reg(1, ADDR_W'(ARG_BASE));
        load_reg(2, ADDR_W'(CODE_BASE + 8 * n_code_words));
        load_reg(3, ADDR_W'(ARG_BASE + 8 * n_arg_words));
        load_reg(4, ADDR_W'(N_INDEX));
    endtask

    task automatic wait_busy(input logic level);
        while (busy !== level)
            @(negedge clk);
    endtask

    task automatic wait_mem_idle();
        while (pend_addr.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic count_pushes(input int n, output int cnt);
        cnt = 0;
        repeat (n) begin
            @(negedge clk);
            if (push_index)
                cnt++;
        end
    endtask

    // memory model and random stalls, all on the falling edge
    always @(negedge clk) begin : mem_model
        logic [ADDR_W-1:0] a;
        rsp_mem_push = 1'b0;
        if (!rst) begin
            if (req_mem_ld) begin
                pend_addr.push_back(req_mem.addr);
                pend_tag.push_back(req_mem.tag);
                pend_due.push_back(cycles + 2 + int'(take_bits(2)));
                log_addr.push_back(req_mem.addr);
                log_tag.push_back(req_mem.tag);
            end
            if (pend_addr.size() != 0 && pend_due[0] <= cycles && !rsp_mem_stall) begin
                a = pend_addr.pop_front();
                rsp_mem.tag = pend_tag.pop_front();
                rsp_mem.data.raw = mem_words[a[14:3]];
                void'(pend_due.pop_front());
                rsp_mem_push = 1'b1;
                rsp_count++;
            end
            req_mem_stall = stall_en && take_bits(2) == 32'd3;
            stall_index = stall_en && take_bits(2) == 32'd3;
        end
    end

    // each pushed pair against the reference sequence
    always @(negedge clk) begin : compare_out
        if (!rst && push_index) begin
            push_count++;
            expect_true(exp_q.size() != 0, "push_index with no expected pair left");
            if (exp_q.size() != 0)
                compare_value("row_col", row_col, exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin : main
        int seen;
        int late;
        int idle;
        build_memory();
        while (rst !== 1'b0)
            @(negedge clk);

        compare_value("busy", busy, 0);
        compare_value("req_mem_ld", req_mem_ld, 0);
        compare_value("rsp_mem_stall", rsp_mem_stall, 0);
        compare_value("push_index", push_index, 0);
        report_test("test 1 reset state");

        load_reg(0, '0);
        load_reg(1, '0);
        load_reg(2, ADDR_W'(8 * 2**MAX_CODE_LEN));
        load_reg(3, ADDR_W'(8 * 2**MAX_CODE_LEN));
        log_addr.delete();
        log_tag.delete();
        drive_op(make_op(OP_LD_CODES, PE_ID + 1, 1'b0, 0, '0));
        repeat (8) begin
            @(negedge clk);
            compare_value("busy", busy, 0);
        end
        expect_true(log_addr.size() == 0, "request issued for a command to another pe");
        rsp_count = 0;
        drive_op(make_op(OP_LD_CODES, PE_ID + 1, 1'b1, 0, '0));
        wait_busy(1'b1);
        report_test("test 2 pe match and broadcast");

        wait_busy(1'b0);
        compare_value("table responses at busy fall", rsp_count, 2**MAX_CODE_LEN);
        wait_mem_idle();
        compare_value("table request count", log_addr.size(), 2**MAX_CODE_LEN);
        for (int i = 0; i < log_addr.size(); i++) begin
            compare_value("req_mem.addr", log_addr[i], 8 * i);
            compare_value("req_mem.tag", log_tag[i], 0);
        end
        report_test("test 3 table load");

        exp_q = ref_seq;
        push_count = 0;
        load_stream_regs();
        stall_en = 1'b1;
        drive_op(make_op(OP_STEADY, PE_ID, 1'b0, 0, '0));
        wait_busy(1'b1);
        wait_busy(1'b0);
        report_test("test 4 steady decode");

        count_pushes(20, idle);
        compare_value("push count", push_count, N_INDEX);
        compare_value("pairs left over", exp_q.size(), 0);
        compare_value("push_index after count", idle, 0);
        report_test("test 5 element count");

        wait_mem_idle();
        drive_op(make_op(OP_RST, PE_ID, 1'b0, 0, '0));
        wait_mem_idle();
        exp_q = ref_seq;
        load_stream_regs();
        drive_op(make_op(OP_STEADY, PE_ID, 1'b0, 0, '0));
        seen = 0;
        while (seen < N_INDEX / 2) begin
            @(negedge clk);
            if (push_index)
                seen++;
        end
        op = make_op(OP_RST, PE_ID, 1'b0, 0, '0);
        @(negedge clk);
        op = '0;
        late = push_index ? 1 : 0;
        count_pushes(8, idle);
        late += idle;
        compare_value("busy", busy, 0);
        expect_true(late <= 3, "too many push_index pulses after the reset command");
        count_pushes(20, idle);
        compare_value("push_index after drain", idle, 0);
        exp_q.delete();
        stall_en = 1'b0;
        report_test("test 6 reset command");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sparse_index_decoder.f */
src/smd_pkg.sv
src/word_fifo.sv
src/bit_buffer.sv
src/response_router.sv
src/code_table_decoder.sv
src/index_accumulator.sv
src/decoder_control.sv
src/sparse_index_decoder.sv
verif/tb_clock_gen.sv
verif/sparse_index_decoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= sparse_index_decoder_tb
FILELIST ?= sparse_index_decoder.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
